/* src.f */
logic/obj_pkg.sv
logic/bus_pkg.sv
logic/obj_line_buf.sv
logic/obj_bus_arbiter.sv
logic/obj_scan.sv
logic/obj_draw.sv
logic/obj_video_top.sv
tb/obj_tb_mem.sv
tb/obj_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = obj_tb
FILELIST = src.f

SOURCES = $(shell grep -v '^+' $(FILELIST))
BIN = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

/* tb/obj_tb.sv */
`timescale 1ns/100ps
// Object layer testbench with clock, reset, line sequencing, reference line and pixel checker
module obj_tb
    import obj_pkg::*;
    import bus_pkg::*;
();

    localparam int AW = 9;
    localparam int OBJ_COUNT = 32;
    localparam int BLANK_DLY = 2;
    localparam int MAW = 16;
    localparam int NPIX = 2**AW;
    // Cycles given to each line
    localparam int LINE_CYC = 1200;
    // Lines drawn one after another with the first in the low byte
    localparam logic [23:0] TEST_LINES = {8'd200, 8'd120, 8'd3};

    logic clk;
    logic arst_n;
    logic lhbl;
    logic [7:0] vrender;
    logic [AW-1:0] pix_addr;
    logic pix_rd;
    pix_t pix_data;
    logic [MAW-1:0] araddr;
    logic arvalid;
    logic arready;
    logic [BUS_DW-1:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic mem_stuck;

    int cyc = 0;
    // Checker state
    logic rd_d1 = 1'b0;
    logic [AW-1:0] addr_d1 = '0;
    logic expect_blank = 1'b1;
    int n_checked = 0;
    pix_t exp_pix [NPIX];

    obj_video_top #(
        .AW(AW), .OBJ_COUNT(OBJ_COUNT), .BLANK_DLY(BLANK_DLY), .MAW(MAW)
    ) UUT (
        .clk, .arst_n, .lhbl, .vrender,
        .pix_addr, .pix_rd, .pix_data,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
    );

    obj_tb_mem #(
        .MAW(MAW), .OBJ_COUNT(OBJ_COUNT), .LINES(TEST_LINES), .SEED(44), .MAX_LAT(6)
    ) mem_model (
        .clk, .arst_n,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .stuck (mem_stuck)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // Expected visible line for vrender v with objects drawn in table order
    function automatic void expected_line(input logic [7:0] v);
        logic [31:0] attr;
        logic [31:0] row_word;
        logic [7:0] dy;
        logic [AW-1:0] x;
        int gfx_addr;
        for (int p = 0; p < NPIX; p++) begin
            exp_pix[p] = 8'hFF;
        end
        for (int i = 0; i < OBJ_COUNT; i++) begin
            attr = mem_model.mem['h0000 + i];
            // Row inside the object modulo 256
            dy = v - attr[16:9];
            if (dy < 8'd8) begin
                gfx_addr = 'h1000 + int'(attr[24:17]) * 8 + int'(dy);
                row_word = mem_model.mem[gfx_addr];
                for (int c = 0; c < 8; c++) begin
                    // Color F keeps whatever lies below
                    if (row_word[4*c +: 4] != 4'hF) begin
                        x = attr[8:0] + AW'(c);
                        exp_pix[x] = {attr[28:25], row_word[4*c +: 4]};
                    end
                end
            end
        end
    endfunction

    // One cycle of lhbl low starts a line
    task automatic start_line(input logic [7:0] v);
        @(posedge clk);
        vrender <= v;
        lhbl <= 1'b0;
        @(posedge clk);
        lhbl <= 1'b1;
    endtask

    // Pad the line to its full length
    task automatic hold_line(input int t0);
        while (cyc - t0 < LINE_CYC) begin
            @(posedge clk);
        end
    endtask

    // Read every address of the visible half and let the erase drain
    task automatic read_line();
        for (int a = 0; a < NPIX; a++) begin
            @(posedge clk);
            pix_addr <= AW'(a);
            pix_rd <= 1'b1;
        end
        @(posedge clk);
        pix_rd <= 1'b0;
        repeat (BLANK_DLY + 2) @(posedge clk);
    endtask

    // Data shows up one cycle after the read
    always @(posedge clk) begin
        pix_t want;
        rd_d1 <= pix_rd;
        addr_d1 <= pix_addr;
        if (rd_d1) begin
            want = expect_blank ? pix_t'(8'hFF) : exp_pix[addr_d1];
            n_checked <= n_checked + 1;
            assert (pix_data == want) else begin
                $display("[FAIL] %0t: pixel %0d reads %h, expected %h",
                    $time, addr_d1, pix_data, want);
                abort_run("display returned a wrong pixel");
            end
        end
    end

    always @(posedge clk) begin
        if (mem_stuck) begin
            abort_run("memory read data was never accepted by the DUT");
        end
    end

    initial begin
        logic [7:0] next_v;
        int t0;
        arst_n = 1'b0;
        lhbl = 1'b1;
        vrender = '0;
        pix_addr = '0;
        pix_rd = 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        assert (!arvalid && !rready) else begin
            $display("[FAIL] %0t: arvalid %b rready %b after reset", $time, arvalid, rready);
            abort_run("memory bus active after reset");
        end
        // Fresh buffer reads blank
        read_line();
        start_line(TEST_LINES[7:0]);
        t0 = cyc;
        hold_line(t0);
        // Show line n while line n+1 is drawn into the other half
        for (int n = 0; n < 3; n++) begin
            next_v = (n < 2) ? TEST_LINES[8*(n+1) +: 8] : TEST_LINES[8*n +: 8];
            start_line(next_v);
            t0 = cyc;
            expected_line(TEST_LINES[8*n +: 8]);
            expect_blank = 1'b0;
            read_line();
            // Second pass sees only erased pixels
            expect_blank = 1'b1;
            read_line();
            hold_line(t0);
        end
        if (n_checked == 7 * NPIX) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run("not every displayed pixel was compared");
        end
    end

endmodule

/* tb/obj_tb_mem.sv */
`timescale 1ns/100ps
// AXI4-Lite read memory model with random latency, random object table and random graphics
module obj_tb_mem
    import obj_pkg::*;
    import bus_pkg::*;
#(
    parameter int MAW = 16,
    parameter int OBJ_COUNT = 32,
    // Tested lines packed one byte each with line 0 in the low byte
    parameter logic [23:0] LINES = 24'h0,
    parameter int SEED = 1,
    parameter int MAX_LAT = 6
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [MAW-1:0]    araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [BUS_DW-1:0] rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready,
    // Raised when the R beat is never taken
    output logic              stuck
);

    logic [BUS_DW-1:0] mem [2**MAW];

    initial begin
        int sel;
        int tries;
        logic [MAW-1:0] addr_q;
        // Table and latencies all come from one seeded stream
        void'($urandom(SEED));
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = OKAY;
        stuck = 1'b0;
        for (int a = 0; a < 2**MAW; a++) begin
            mem[a] = $urandom;
            // Extra transparent pixels in part of the graphics rows
            if (a >= int'(GFX_BASE) && a % 3 == 0) begin
                mem[a] = mem[a] | 32'hF00F_0F00;
            end
        end
        // About a quarter of the entries sit just above each tested line
        // Those cluster around x = 511 so they overlap and wrap
        for (int i = 0; i < OBJ_COUNT; i++) begin
            sel = $urandom_range(3, 0);
            if (sel < 3) begin
                mem[int'(ATTR_BASE) + i][Y_LSB +: Y_W] =
                    LINES[8*sel +: 8] - 8'($urandom_range(9, 0));
                mem[int'(ATTR_BASE) + i][X_LSB +: X_W] = 9'(496 + $urandom_range(31, 0));
            end
        end
        // One read at a time with AR after a random delay and R after another
        forever begin
            @(posedge clk);
            if (arst_n && arvalid) begin
                repeat ($urandom_range(MAX_LAT, 0)) @(posedge clk);
                arready <= 1'b1;
                @(posedge clk);
                addr_q = araddr;
                arready <= 1'b0;
                repeat ($urandom_range(MAX_LAT, 0)) @(posedge clk);
                rvalid <= 1'b1;
                rdata <= mem[addr_q];
                rresp <= OKAY;
                tries = 0;
                do begin
                    @(posedge clk);
                    tries++;
                end while (!rready && tries < 64);
                rvalid <= 1'b0;
                if (!rready) begin
                    stuck <= 1'b1;
                end
            end
        end
    end

endmodule

/* logic/obj_video_top.sv */
`timescale 1ns/100ps
// Object layer top level with scanner, drawer, bus arbiter and line buffer
module obj_video_top
    import obj_pkg::*;
    import bus_pkg::*;
#(
    parameter int AW = 9,
    parameter int OBJ_COUNT = 32,
    parameter int BLANK_DLY = 2,
    parameter int MAW = 16
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              lhbl,
    input  logic [Y_W-1:0]    vrender,
    // Display side
    input  logic [AW-1:0]     pix_addr,
    input  logic              pix_rd,
    output pix_t              pix_data,
    // Memory read port
    output logic [MAW-1:0]    araddr,
    output logic              arvalid,
    input  logic              arready,
    input  logic [BUS_DW-1:0] rdata,
    input  logic [1:0]        rresp,
    input  logic              rvalid,
    output logic              rready
);

    // Scanner bus
    logic [MAW-1:0] scan_araddr;
    logic scan_arvalid;
    logic scan_arready;
    logic [BUS_DW-1:0] scan_rdata;
    logic [1:0] scan_rresp;
    logic scan_rvalid;
    logic scan_rready;
    // Drawer bus
    logic [MAW-1:0] draw_araddr;
    logic draw_arvalid;
    logic draw_arready;
    logic [BUS_DW-1:0] draw_rdata;
    logic [1:0] draw_rresp;
    logic draw_rvalid;
    logic draw_rready;
    // Object handoff
    logic obj_valid;
    logic obj_ready;
    logic [X_W-1:0] obj_x;
    logic [CODE_W-1:0] obj_code;
    logic [ROW_W-1:0] obj_row;
    logic [PAL_W-1:0] obj_pal;
    // Pixel writes
    logic [AW-1:0] wr_addr;
    pix_t wr_data;
    logic we;

    obj_scan #(.OBJ_COUNT(OBJ_COUNT), .MAW(MAW)) u_scan (
        .clk, .arst_n, .lhbl, .vrender,
        .scan_araddr, .scan_arvalid, .scan_arready,
        .scan_rdata, .scan_rresp, .scan_rvalid, .scan_rready,
        .obj_ready, .obj_valid, .obj_x, .obj_code, .obj_row, .obj_pal
    );

    obj_draw #(.AW(AW), .MAW(MAW)) u_draw (
        .clk, .arst_n,
        .obj_valid, .obj_ready, .obj_x, .obj_code, .obj_row, .obj_pal,
        .draw_araddr, .draw_arvalid, .draw_arready,
        .draw_rdata, .draw_rresp, .draw_rvalid, .draw_rready,
        .wr_addr, .wr_data, .we
    );

    obj_bus_arbiter #(.MAW(MAW)) u_arb (
        .clk, .arst_n,
        .scan_araddr, .scan_arvalid, .scan_arready,
        .scan_rdata, .scan_rresp, .scan_rvalid, .scan_rready,
        .draw_araddr, .draw_arvalid, .draw_arready,
        .draw_rdata, .draw_rresp, .draw_rvalid, .draw_rready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
    );

    // Display reads the half drawn during the previous line
    obj_line_buf #(.AW(AW), .BLANK_DLY(BLANK_DLY)) u_buf (
        .clk, .arst_n, .lhbl,
        .wr_addr, .wr_data, .we,
        .rd_addr (pix_addr),
        .rd      (pix_rd),
        .rd_data (pix_data)
    );

endmodule

/* logic/obj_draw.sv */
`timescale 1ns/100ps
// Object drawer fetching one graphics row per object and writing it to the line buffer
module obj_draw
    import obj_pkg::*;
    import bus_pkg::*;
#(
    parameter int AW = 9,
    parameter int MAW = 16
) (
    input  logic              clk,
    input  logic              arst_n,
    // Object handoff
    input  logic              obj_valid,
    output logic              obj_ready,
    input  logic [X_W-1:0]    obj_x,
    input  logic [CODE_W-1:0] obj_code,
    input  logic [ROW_W-1:0]  obj_row,
    input  logic [PAL_W-1:0]  obj_pal,
    // Read master
    output logic [MAW-1:0]    draw_araddr,
    output logic              draw_arvalid,
    input  logic              draw_arready,
    input  logic [BUS_DW-1:0] draw_rdata,
    input  logic [1:0]        draw_rresp,
    input  logic              draw_rvalid,
    output logic              draw_rready,
    // Line buffer writes
    output logic [AW-1:0]     wr_addr,
    output pix_t              wr_data,
    output logic              we
);

    localparam int COL_W = $clog2(OBJ_W);

    draw_state_t state;
    logic [X_W-1:0] x_q;
    logic [CODE_W-1:0] code_q;
    logic [ROW_W-1:0] row_q;
    logic [PAL_W-1:0] pal_q;
    // Graphics row with the current pixel always in the low nibble
    logic [BUS_DW-1:0] gfx;
    logic [COL_W-1:0] col;

    assign obj_ready = state == DRAW_IDLE;

    // Row word at GFX_BASE + code*8 + row
    assign draw_araddr = MAW'(GFX_BASE) + MAW'({code_q, row_q});
    assign draw_arvalid = state == DRAW_REQ;
    assign draw_rready = state == DRAW_WAIT;

    // Address wraps at the line end
    assign wr_addr = AW'(x_q) + AW'(col);
    assign wr_data.pal = pal_q;
    assign wr_data.color = gfx[COLOR_W-1:0];
    assign we = state == DRAW_WRITE;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= DRAW_IDLE;
            col <= '0;
        end else begin
            case (state)
                DRAW_IDLE: begin
                    if (obj_valid) begin
                        state <= DRAW_REQ;
                    end
                end
                DRAW_REQ: begin
                    if (draw_arready) begin
                        state <= DRAW_WAIT;
                    end
                end
                DRAW_WAIT: begin
                    // An object whose row cannot be read is dropped
                    if (draw_rvalid) begin
                        col <= '0;
                        state <= (resp_t'(draw_rresp) == OKAY) ? DRAW_WRITE : DRAW_IDLE;
                    end
                end
                default: begin
                    col <= col + 1'b1;
                    if (col == COL_W'(OBJ_W - 1)) begin
                        state <= DRAW_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (obj_valid && obj_ready) begin
            x_q <= obj_x;
            code_q <= obj_code;
            row_q <= obj_row;
            pal_q <= obj_pal;
        end
        if (state == DRAW_WAIT && draw_rvalid) begin
            gfx <= draw_rdata;
        end else if (state == DRAW_WRITE) begin
            gfx <= gfx >> COLOR_W;
        end
    end

endmodule

/* logic/obj_scan.sv */
`timescale 1ns/100ps
// Object scanner walking the attribute table and passing visible objects to the drawer
module obj_scan
    import obj_pkg::*;
    import bus_pkg::*;
#(
    parameter int OBJ_COUNT = 32,
    parameter int MAW = 16
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              lhbl,
    input  logic [Y_W-1:0]    vrender,
    // Read master
    output logic [MAW-1:0]    scan_araddr,
    output logic              scan_arvalid,
    input  logic              scan_arready,
    input  logic [BUS_DW-1:0] scan_rdata,
    input  logic [1:0]        scan_rresp,
    input  logic              scan_rvalid,
    output logic              scan_rready,
    // Object handoff
    input  logic              obj_ready,
    output logic              obj_valid,
    output logic [X_W-1:0]    obj_x,
    output logic [CODE_W-1:0] obj_code,
    output logic [ROW_W-1:0]  obj_row,
    output logic [PAL_W-1:0]  obj_pal
);

    localparam int IW = $clog2(OBJ_COUNT);

    scan_state_t state;
    logic lhbl_q;
    logic line_start;
    logic [IW-1:0] idx;
    logic [Y_W-1:0] v_q;
    logic [BUS_DW-1:0] attr;
    logic attr_ok;
    logic [Y_W-1:0] dy;
    logic hit;
    logic slot_free;
    logic advance;
    logic done;

    assign line_start = lhbl_q && !lhbl;
    // Row inside the object wraps modulo 256
    assign dy = v_q - attr[Y_LSB +: Y_W];
    assign hit = attr_ok && (dy < Y_W'(OBJ_H));
    // Handoff register empty or emptying this cycle
    assign slot_free = !obj_valid || obj_ready;
    assign advance = (state == SCAN_TEST && !hit) || (state == SCAN_HAND && slot_free);

    assign scan_arvalid = state == SCAN_REQ;
    assign scan_araddr = MAW'(ATTR_BASE) + MAW'(idx);
    assign scan_rready = state == SCAN_WAIT;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= SCAN_IDLE;
            lhbl_q <= 1'b0;
            idx <= '0;
            v_q <= '0;
            attr_ok <= 1'b0;
            obj_valid <= 1'b0;
            done <= 1'b1;
        end else begin
            lhbl_q <= lhbl;
            if (obj_valid && obj_ready) begin
                obj_valid <= 1'b0;
            end
            case (state)
                SCAN_IDLE: begin
                    if (line_start) begin
                        v_q <= vrender;
                        idx <= '0;
                        done <= 1'b0;
                        state <= SCAN_REQ;
                    end
                end
                SCAN_REQ: begin
                    if (scan_arready) begin
                        state <= SCAN_WAIT;
                    end
                end
                SCAN_WAIT: begin
                    // Failed reads are skipped
                    if (scan_rvalid) begin
                        attr_ok <= resp_t'(scan_rresp) == OKAY;
                        state <= SCAN_TEST;
                    end
                end
                SCAN_TEST: begin
                    if (hit) begin
                        state <= SCAN_HAND;
                    end
                end
                default: begin
                    if (slot_free) begin
                        obj_valid <= 1'b1;
                    end
                end
            endcase
            // Next entry or end of table
            if (advance) begin
                if (idx == IW'(OBJ_COUNT - 1)) begin
                    done <= 1'b1;
                    state <= SCAN_IDLE;
                end else begin
                    idx <= idx + 1'b1;
                    state <= SCAN_REQ;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == SCAN_WAIT && scan_rvalid) begin
            attr <= scan_rdata;
        end
        if (state == SCAN_HAND && slot_free) begin
            obj_x <= attr[X_LSB +: X_W];
            obj_code <= attr[CODE_LSB +: CODE_W];
            obj_row <= dy[ROW_W-1:0];
            obj_pal <= attr[PAL_LSB +: PAL_W];
        end
    end

    // The whole table is scanned within one line
    a_scan_done: assert property (@(posedge clk) disable iff (!arst_n)
        line_start |-> done);

endmodule

/* logic/obj_bus_arbiter.sv */
`timescale 1ns/100ps
// Round-robin arbiter joining the scanner and drawer AXI4-Lite read masters
module obj_bus_arbiter
    import bus_pkg::*;
#(
    parameter int MAW = 16
) (
    input  logic              clk,
    input  logic              arst_n,
    // Scanner
    input  logic [MAW-1:0]    scan_araddr,
    input  logic              scan_arvalid,
    output logic              scan_arready,
    output logic [BUS_DW-1:0] scan_rdata,
    output logic [1:0]        scan_rresp,
    output logic              scan_rvalid,
    input  logic              scan_rready,
    // Drawer
    input  logic [MAW-1:0]    draw_araddr,
    input  logic              draw_arvalid,
    output logic              draw_arready,
    output logic [BUS_DW-1:0] draw_rdata,
    output logic [1:0]        draw_rresp,
    output logic              draw_rvalid,
    input  logic              draw_rready,
    // Memory
    output logic [MAW-1:0]    araddr,
    output logic              arvalid,
    input  logic              arready,
    input  logic [BUS_DW-1:0] rdata,
    input  logic [1:0]        rresp,
    input  logic              rvalid,
    output logic              rready
);

    arb_state_t state;
    // Bit 0 for the scanner and bit 1 for the drawer
    logic [1:0] gnt;
    logic [1:0] req;
    logic last_draw;

    assign req = {draw_arvalid, scan_arvalid};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= FREE;
            gnt <= 2'b00;
            last_draw <= 1'b0;
        end else begin
            case (state)
                FREE: begin
                    if (|req) begin
                        // On a tie the master not served last wins
                        gnt <= (req == 2'b11) ? (last_draw ? 2'b01 : 2'b10) : req;
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    if (arvalid && arready) begin
                        state <= DATA;
                    end
                end
                default: begin
                    // Grant is dropped only once the R beat is taken
                    if (rvalid && rready) begin
                        last_draw <= gnt[1];
                        gnt <= 2'b00;
                        state <= FREE;
                    end
                end
            endcase
        end
    end

    // AR channel to the granted master
    assign arvalid = (state == ADDR) && |(gnt & req);
    assign araddr = gnt[1] ? draw_araddr : scan_araddr;
    assign scan_arready = (state == ADDR) && gnt[0] && arready;
    assign draw_arready = (state == ADDR) && gnt[1] && arready;

    // Data and response go to both masters but valid only to the owner
    assign rready = (state == DATA) && |(gnt & {draw_rready, scan_rready});
    assign scan_rvalid = (state == DATA) && gnt[0] && rvalid;
    assign draw_rvalid = (state == DATA) && gnt[1] && rvalid;
    assign scan_rdata = rdata;
    assign draw_rdata = rdata;
    assign scan_rresp = rresp;
    assign draw_rresp = rresp;

    // Never two owners at once
    a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(gnt));

    // Master keeps its request steady while the memory stalls
    a_ar_stable: assert property (@(posedge clk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

/* logic/obj_line_buf.sv */
`timescale 1ns/100ps
// Double-buffered object line buffer with transparent writes and erase after read
module obj_line_buf
    import obj_pkg::*;
#(
    parameter int AW = 9,
    parameter int BLANK_DLY = 2
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          lhbl,
    // Drawer side
    input  logic [AW-1:0] wr_addr,
    input  pix_t          wr_data,
    input  logic          we,
    // Display side
    input  logic [AW-1:0] rd_addr,
    input  logic          rd,
    output pix_t          rd_data
);

    // Both halves in one array
    // MSB of the index picks the half
    pix_t mem [2**(AW+1)];

    logic lhbl_q;
    // Half being drawn while the other one is shown
    logic half;
    logic wr_ok;
    logic [AW:0] wr_idx;
    // Erase pipeline with one stage per cycle of delay
    logic [BLANK_DLY-1:0] er_v;
    logic [AW:0] er_idx [BLANK_DLY];
    logic er_we;

    assign wr_ok = we && (wr_data.color != ALPHA);
    assign wr_idx = {half, wr_addr};
    assign er_we = er_v[BLANK_DLY-1];

    // Line buffer comes up blank
    initial begin
        for (int i = 0; i < 2**(AW+1); i++) begin
            mem[i] = BLANK_PIX;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lhbl_q <= 1'b0;
            half <= 1'b0;
            er_v <= '0;
        end else begin
            lhbl_q <= lhbl;
            // Swap halves on falling line blank
            if (lhbl_q && !lhbl) begin
                half <= ~half;
            end
            er_v <= BLANK_DLY'({er_v, rd});
        end
    end

    // Read address travels with the erase flag
    // Half is kept too so a pending erase survives a swap
    always_ff @(posedge clk) begin
        er_idx[0] <= {~half, rd_addr};
        for (int i = 1; i < BLANK_DLY; i++) begin
            er_idx[i] <= er_idx[i-1];
        end
    end

    always @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_idx] <= wr_data;
        end
        if (er_we) begin
            mem[er_idx[BLANK_DLY-1]] <= BLANK_PIX;
        end
        if (rd) begin
            rd_data <= mem[{~half, rd_addr}];
        end
    end

    // Anything read back is either blank or an opaque pixel
    a_no_alpha: assert property (@(posedge clk) disable iff (!arst_n)
        rd |=> (rd_data == BLANK_PIX) || (rd_data.color != ALPHA));

endmodule

/* logic/bus_pkg.sv */
// AXI4-Lite read response codes, arbiter FSM states and memory map of the object layer
package bus_pkg;

    // Read data width of the memory port
    localparam int BUS_DW = 32;

    // AXI4-Lite RRESP encoding
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_t;

    // Arbiter phases
    // FREE waits for a request while ADDR and DATA carry the AR and R transfers
    typedef enum logic [1:0] {FREE, ADDR, DATA} arb_state_t;

    // Word addresses
    // Attribute table with one word per object
    localparam logic [15:0] ATTR_BASE = 16'h0000;
    // Graphics with one word per object row at GFX_BASE + code*8 + row
    // Pixel 0 sits in bits 3:0
    localparam logic [15:0] GFX_BASE = 16'h1000;

endpackage

/* logic/obj_pkg.sv */
// Object pixel format, geometry, attribute word layout and scanner/drawer FSM states
package obj_pkg;

    // Pixel fields
    localparam int PAL_W = 4;
    localparam int COLOR_W = 4;

    // Palette in the upper nibble and color in the lower one
    typedef struct packed {
        logic [PAL_W-1:0]   pal;
        logic [COLOR_W-1:0] color;
    } pix_t;

    // Color that is never written
    localparam logic [COLOR_W-1:0] ALPHA = 4'hF;
    // Value left behind after a pixel is shown
    localparam pix_t BLANK_PIX = 8'hFF;

    // Object size in pixels
    localparam int OBJ_W = 8;
    localparam int OBJ_H = 8;
    localparam int ROW_W = 3;

    // Attribute word layout
    localparam int X_LSB = 0;
    localparam int X_W = 9;
    localparam int Y_LSB = 9;
    localparam int Y_W = 8;
    localparam int CODE_LSB = 17;
    localparam int CODE_W = 8;
    localparam int PAL_LSB = 25;

    typedef enum logic [2:0] {SCAN_IDLE, SCAN_REQ, SCAN_WAIT, SCAN_TEST, SCAN_HAND} scan_state_t;
    typedef enum logic [1:0] {DRAW_IDLE, DRAW_REQ, DRAW_WAIT, DRAW_WRITE} draw_state_t;

endpackage
